// ==== src/zx_io_pkg.sv ====
package zx_io_pkg;

	// ====================
	// Bus widths
	// ====================
	localparam int CPU_ADDR_W = 16;
	localparam int DATA_W     = 8;

	// ====================
	// Port decoding
	// ====================

	// 128K paging port, A15 and A1 low
	localparam logic [CPU_ADDR_W-1:0] PORT_7FFD_WINDOW = 16'h8002;

	// +3 paging port, A15..A12 = 0001 and A1 low
	localparam logic [CPU_ADDR_W-1:0] PORT_1FFD_WINDOW = 16'hF002;
	localparam logic [CPU_ADDR_W-1:0] PORT_1FFD_MATCH  = 16'h1000;

	// ULA answers on every even port
	localparam int ULA_PORT_BIT = 0;

	// Nothing drives the bus
	localparam logic [DATA_W-1:0] FLOAT_BUS = 8'hFF;

	// ====================
	// Beeper DAC
	// ====================

	// Accumulator with one carry bit on top
	localparam int DAC_W = 9;

	localparam logic [DAC_W-2:0] EAR_LEVEL  = 8'd64;
	localparam logic [DAC_W-2:0] MIC_LEVEL  = 8'd32;
	localparam logic [DAC_W-2:0] TAPE_LEVEL = 8'd16;

endpackage

// ==== src/zx_mem_pkg.sv ====
package zx_mem_pkg;

	// Machine model, sampled while reset is held
	typedef enum logic [1:0] {
		MODEL_128K  = 2'd0,
		MODEL_48K   = 2'd1,
		MODEL_PLUS3 = 2'd2
	} machine_t;

	// ====================
	// Memory map
	// ====================

	// One 16K window
	localparam int PAGE_OFFSET_W = 14;

	localparam int RAM_BANK_W = 3;
	localparam int ROM_BANK_W = 2;

	// Region bit (1 = ROM), bank bits, offset
	localparam int MEM_ADDR_W = 1 + RAM_BANK_W + PAGE_OFFSET_W;

	// Fixed banks behind 4000h and 8000h in normal mode
	localparam logic [RAM_BANK_W-1:0] RAM_SCREEN_BANK_A = 3'd5;
	localparam logic [RAM_BANK_W-1:0] RAM_SCREEN_BANK_B = 3'd2;

	// ====================
	// Paging register bits
	// ====================

	// 7FFD
	localparam int SCREEN_BIT = 3;
	localparam int ROM_LO_BIT = 4;
	localparam int LOCK_BIT   = 5;

	// 1FFD
	localparam int SPECIAL_BIT = 0;
	localparam int ROM_HI_BIT  = 2;

endpackage

// ==== src/zx_bus_ctrl.sv ====
module zx_bus_ctrl (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic [zx_io_pkg::CPU_ADDR_W-1:0]  addr,
	input  logic                              mreq_n,
	input  logic                              iorq_n,
	input  logic                              rd_n,
	input  logic                              wr_n,
	input  logic                              m1_n,
	input  logic [zx_io_pkg::DATA_W-1:0]      ram_dout,
	input  logic                              tape_in,
	input  logic [4:0]                        key_data,
	output logic                              mem_rd,
	output logic                              mem_wr,
	output logic                              io_wr_pulse,
	output logic [zx_io_pkg::DATA_W-1:0]      cpu_din
);

	logic io_rd;
	logic io_wr;
	logic io_wr_q;
	logic ula_sel;

	// ====================
	// Strobes
	// ====================

	assign mem_rd = ~mreq_n & ~rd_n;
	assign mem_wr = ~mreq_n & ~wr_n;

	// M1 with IORQ is an interrupt acknowledge, not a port access
	assign io_rd = ~iorq_n & ~rd_n & m1_n;
	assign io_wr = ~iorq_n & ~wr_n & m1_n;

	// Previous write level for edge detection
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
		end
	end

	// High only in the first cycle of an I/O write
	assign io_wr_pulse = io_wr & ~io_wr_q;

	// ====================
	// Read data mux
	// ====================

	assign ula_sel = ~addr[zx_io_pkg::ULA_PORT_BIT];

	always_comb begin
		if (mem_rd) begin
			cpu_din = ram_dout;
		end else if (io_rd && ula_sel) begin
			// Keyboard half-row in bits 4..0, EAR in bit 6
			cpu_din = {1'b1, tape_in, 1'b1, key_data};
		end else begin
			cpu_din = zx_io_pkg::FLOAT_BUS;
		end
	end

endmodule

// ==== src/zx_paging.sv ====
module zx_paging (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  zx_mem_pkg::machine_t                    machine,
	input  logic [zx_io_pkg::CPU_ADDR_W-1:0]        addr,
	input  logic [zx_io_pkg::DATA_W-1:0]            cpu_dout,
	input  logic                                    io_wr_pulse,
	output logic [zx_mem_pkg::RAM_BANK_W-1:0]       page_ram,
	output logic [zx_mem_pkg::ROM_BANK_W-1:0]       page_rom,
	output logic                                    page_special,
	output logic [1:0]                              special_cfg,
	output logic                                    screen_page
);

	zx_mem_pkg::machine_t model;

	// Bits 7..6 of 7FFD and 7..3 of 1FFD have no function here
	logic [zx_mem_pkg::LOCK_BIT:0]   reg_7ffd;
	logic [zx_mem_pkg::ROM_HI_BIT:0] reg_1ffd;

	logic is_48k;
	logic is_plus3;
	logic locked;
	logic sel_7ffd;
	logic sel_1ffd;

	// ====================
	// Model
	// ====================

	// Switching models only takes effect through a reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model <= machine;
		end
	end

	assign is_48k   = (model == zx_mem_pkg::MODEL_48K);
	assign is_plus3 = (model == zx_mem_pkg::MODEL_PLUS3);

	// 48K never pages, the others stop once the lock bit is written
	assign locked = is_48k | reg_7ffd[zx_mem_pkg::LOCK_BIT];

	// ====================
	// Port decode
	// ====================

	// The +3 also needs A14 high so that 1FFD and the FDC ports do not alias
	assign sel_7ffd = ((addr & zx_io_pkg::PORT_7FFD_WINDOW) == '0)
		& (addr[14] | ~is_plus3);

	assign sel_1ffd = ((addr & zx_io_pkg::PORT_1FFD_WINDOW) == zx_io_pkg::PORT_1FFD_MATCH)
		& is_plus3;

	// ====================
	// Registers
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			reg_7ffd <= '0;
			reg_1ffd <= '0;
		end else if (io_wr_pulse && !locked) begin
			if (sel_7ffd) begin
				reg_7ffd <= cpu_dout[zx_mem_pkg::LOCK_BIT:0];
			end else if (sel_1ffd) begin
				reg_1ffd <= cpu_dout[zx_mem_pkg::ROM_HI_BIT:0];
			end
		end
	end

	// ====================
	// Outputs
	// ====================

	assign page_ram     = reg_7ffd[zx_mem_pkg::RAM_BANK_W-1:0];
	assign screen_page  = reg_7ffd[zx_mem_pkg::SCREEN_BIT];
	assign page_special = reg_1ffd[zx_mem_pkg::SPECIAL_BIT];
	assign special_cfg  = reg_1ffd[zx_mem_pkg::ROM_HI_BIT:1];

	// ROM select
	always_comb begin
		if (is_48k) begin
			// BASIC ROM only
			page_rom = 2'd1;
		end else if (is_plus3) begin
			page_rom = {reg_1ffd[zx_mem_pkg::ROM_HI_BIT], reg_7ffd[zx_mem_pkg::ROM_LO_BIT]};
		end else begin
			page_rom = {1'b0, reg_7ffd[zx_mem_pkg::ROM_LO_BIT]};
		end
	end

endmodule

// ==== src/zx_ram_map.sv ====
module zx_ram_map (
	input  logic [zx_mem_pkg::PAGE_OFFSET_W+1:0]    addr,
	input  logic                                    mem_rd,
	input  logic                                    mem_wr,
	input  logic [zx_mem_pkg::RAM_BANK_W-1:0]       page_ram,
	input  logic [zx_mem_pkg::ROM_BANK_W-1:0]       page_rom,
	input  logic                                    page_special,
	input  logic [1:0]                              special_cfg,
	output logic [zx_mem_pkg::MEM_ADDR_W-1:0]       ram_addr,
	output logic                                    ram_rd,
	output logic                                    ram_we
);

	logic [1:0]                        win;
	logic                              rom_sel;
	logic [zx_mem_pkg::RAM_BANK_W-1:0] bank;

	// +3 all-RAM bank sets
	function automatic logic [zx_mem_pkg::RAM_BANK_W-1:0] special_bank(
		input logic [1:0] cfg,
		input logic [1:0] w
	);
		case (cfg)
			2'd0: special_bank = {1'b0, w};
			2'd1: special_bank = {1'b1, w};
			2'd2: special_bank = (w == 2'd3) ? 3'd3 : {1'b1, w};
			default: begin
				case (w)
					2'd0:    special_bank = 3'd4;
					2'd1:    special_bank = 3'd7;
					2'd2:    special_bank = 3'd6;
					default: special_bank = 3'd3;
				endcase
			end
		endcase
	endfunction

	// Top two address bits pick the 16K window
	assign win = addr[zx_mem_pkg::PAGE_OFFSET_W+1:zx_mem_pkg::PAGE_OFFSET_W];

	// ====================
	// Bank select
	// ====================

	always_comb begin
		rom_sel = 1'b0;
		if (page_special) begin
			bank = special_bank(special_cfg, win);
		end else begin
			case (win)
				2'd0: begin
					rom_sel = 1'b1;
					bank    = {{(zx_mem_pkg::RAM_BANK_W-zx_mem_pkg::ROM_BANK_W){1'b0}}, page_rom};
				end
				2'd1:    bank = zx_mem_pkg::RAM_SCREEN_BANK_A;
				2'd2:    bank = zx_mem_pkg::RAM_SCREEN_BANK_B;
				default: bank = page_ram;
			endcase
		end
	end

	assign ram_addr = {rom_sel, bank, addr[zx_mem_pkg::PAGE_OFFSET_W-1:0]};

	// ====================
	// Enables
	// ====================

	assign ram_rd = mem_rd;

	// ROM window is read only outside the all-RAM modes
	assign ram_we = mem_wr & ~rom_sel;

endmodule

// ==== src/zx_ula_port.sv ====
module zx_ula_port (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic [zx_io_pkg::CPU_ADDR_W-1:0]  addr,
	input  logic [zx_io_pkg::DATA_W-1:0]      cpu_dout,
	input  logic                              io_wr_pulse,
	input  logic                              tape_in,
	output logic [2:0]                        border_color,
	output logic                              audio
);

	logic                          ear_out;
	logic                          mic_out;
	logic [zx_io_pkg::DAC_W-2:0]   dac_in;
	logic [zx_io_pkg::DAC_W-1:0]   dac_acc;

	// ====================
	// Port FE
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= '0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (io_wr_pulse && !addr[zx_io_pkg::ULA_PORT_BIT]) begin
			border_color <= cpu_dout[2:0];
			ear_out      <= cpu_dout[4];
			mic_out      <= cpu_dout[3];
		end
	end

	// ====================
	// Beeper DAC
	// ====================

	// Levels are distinct powers of two, so the sum never overflows
	assign dac_in = (ear_out ? zx_io_pkg::EAR_LEVEL  : '0)
		| (mic_out ? zx_io_pkg::MIC_LEVEL  : '0)
		| (tape_in ? zx_io_pkg::TAPE_LEVEL : '0);

	// First order sigma-delta, the carry out is the pulse stream
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dac_acc <= '0;
		end else begin
			dac_acc <= {1'b0, dac_acc[zx_io_pkg::DAC_W-2:0]} + {1'b0, dac_in};
		end
	end

	assign audio = dac_acc[zx_io_pkg::DAC_W-1];

endmodule

// ==== src/zx_host.sv ====
module zx_host (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  zx_mem_pkg::machine_t                machine,
	input  logic [zx_io_pkg::CPU_ADDR_W-1:0]    addr,
	input  logic [zx_io_pkg::DATA_W-1:0]        cpu_dout,
	input  logic                                mreq_n,
	input  logic                                iorq_n,
	input  logic                                rd_n,
	input  logic                                wr_n,
	input  logic                                m1_n,
	input  logic [zx_io_pkg::DATA_W-1:0]        ram_dout,
	input  logic                                tape_in,
	input  logic [4:0]                          key_data,
	output logic [zx_io_pkg::DATA_W-1:0]        cpu_din,
	output logic [zx_mem_pkg::MEM_ADDR_W-1:0]   ram_addr,
	output logic                                ram_rd,
	output logic                                ram_we,
	output logic                                screen_page,
	output logic [2:0]                          border_color,
	output logic                                audio
);

	// Bus strobes
	logic mem_rd;
	logic mem_wr;
	logic io_wr_pulse;

	// Paging state towards the address mapper
	logic [zx_mem_pkg::RAM_BANK_W-1:0] page_ram;
	logic [zx_mem_pkg::ROM_BANK_W-1:0] page_rom;
	logic                              page_special;
	logic [1:0]                        special_cfg;

	zx_bus_ctrl i_bus_ctrl (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.addr        (addr),
		.mreq_n      (mreq_n),
		.iorq_n      (iorq_n),
		.rd_n        (rd_n),
		.wr_n        (wr_n),
		.m1_n        (m1_n),
		.ram_dout    (ram_dout),
		.tape_in     (tape_in),
		.key_data    (key_data),
		.mem_rd      (mem_rd),
		.mem_wr      (mem_wr),
		.io_wr_pulse (io_wr_pulse),
		.cpu_din     (cpu_din)
	);

	zx_paging i_paging (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine      (machine),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.io_wr_pulse  (io_wr_pulse),
		.page_ram     (page_ram),
		.page_rom     (page_rom),
		.page_special (page_special),
		.special_cfg  (special_cfg),
		.screen_page  (screen_page)
	);

	zx_ram_map i_ram_map (
		.addr         (addr),
		.mem_rd       (mem_rd),
		.mem_wr       (mem_wr),
		.page_ram     (page_ram),
		.page_rom     (page_rom),
		.page_special (page_special),
		.special_cfg  (special_cfg),
		.ram_addr     (ram_addr),
		.ram_rd       (ram_rd),
		.ram_we       (ram_we)
	);

	zx_ula_port i_ula_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.io_wr_pulse  (io_wr_pulse),
		.tape_in      (tape_in),
		.border_color (border_color),
		.audio        (audio)
	);

endmodule

// ==== testbench/zx_host_properties.sv ====
module zx_host_properties (
	input logic                                 clk_sys,
	input logic                                 reset,
	input zx_mem_pkg::machine_t                 machine,
	input logic [zx_io_pkg::CPU_ADDR_W-1:0]     addr,
	input logic [zx_io_pkg::DATA_W-1:0]         cpu_dout,
	input logic                                 mreq_n,
	input logic                                 iorq_n,
	input logic                                 rd_n,
	input logic                                 wr_n,
	input logic                                 m1_n,
	input logic [zx_io_pkg::DATA_W-1:0]         ram_dout,
	input logic                                 tape_in,
	input logic [4:0]                           key_data,
	input logic [zx_io_pkg::DATA_W-1:0]         cpu_din,
	input logic [zx_mem_pkg::MEM_ADDR_W-1:0]    ram_addr,
	input logic                                 ram_rd,
	input logic                                 ram_we,
	input logic                                 screen_page,
	input logic [2:0]                           border_color,
	input logic                                 audio
);

	// Details of the latest failed check
	int unsigned fail_count = 0;
	string       fail_name;
	logic [31:0] fail_exp;
	logic [31:0] fail_act;

	// Reference state rebuilt from the bus
	zx_mem_pkg::machine_t                model_q;
	logic [zx_io_pkg::DATA_W-1:0]        exp_7ffd;
	logic [zx_io_pkg::DATA_W-1:0]        exp_1ffd;
	logic [4:0]                          exp_fe;
	logic                                io_wr_seen;
	logic                                quiet_q;
	logic                                io_write;
	logic                                io_read;
	logic                                int_ack;
	logic                                can_page;
	logic                                special;
	logic [11:0]                         bank_set;
	logic [zx_mem_pkg::RAM_BANK_W-1:0]   exp_bank;
	logic                                rom_win;
	logic [zx_mem_pkg::MEM_ADDR_W-1:0]   exp_ram_addr;

	task automatic record_failure(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		fail_name = name;
		fail_exp  = exp;
		fail_act  = act;
		fail_count++;
		$error("%s check failed", name);
	endtask

	// ====================
	// Reference model
	// ====================

	// IORQ together with M1 is an interrupt acknowledge
	assign int_ack  = !iorq_n && !m1_n;
	assign io_write = !iorq_n && !wr_n && m1_n;
	assign io_read  = !iorq_n && !rd_n && m1_n;
	assign can_page = model_q != zx_mem_pkg::MODEL_48K && !exp_7ffd[zx_mem_pkg::LOCK_BIT];
	assign special  = exp_1ffd[zx_mem_pkg::SPECIAL_BIT];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q    <= machine;
			exp_7ffd   <= '0;
			exp_1ffd   <= '0;
			exp_fe     <= '0;
			io_wr_seen <= 1'b0;
			quiet_q    <= 1'b1;
		end else begin
			io_wr_seen <= io_write;
			quiet_q    <= exp_fe[4:3] == 2'b00 && !tape_in;
			// Only the first clock of a port write counts
			if (io_write && !io_wr_seen) begin
				// 7FFD needs A15 and A1 low and on the +3 also A14 high
				if (can_page && !addr[15] && !addr[1]
						&& (addr[14] || model_q != zx_mem_pkg::MODEL_PLUS3)) begin
					exp_7ffd <= cpu_dout;
				end
				if (can_page && addr[15:12] == 4'b0001 && !addr[1]
						&& model_q == zx_mem_pkg::MODEL_PLUS3) begin
					exp_1ffd <= cpu_dout;
				end
				if (!addr[0]) begin
					exp_fe <= cpu_dout[4:0];
				end
			end
		end
	end

	// All-RAM bank sets with window 0 in the lowest octal digit
	always_comb begin
		case (exp_1ffd[2:1])
			2'd0:    bank_set = 12'o3210;
			2'd1:    bank_set = 12'o7654;
			2'd2:    bank_set = 12'o3654;
			default: bank_set = 12'o3674;
		endcase
		rom_win = 1'b0;
		if (special) begin
			exp_bank = bank_set[3 * addr[15:14] +: 3];
		end else begin
			case (addr[15:14])
				2'd0: begin
					rom_win = 1'b1;
					if (model_q == zx_mem_pkg::MODEL_48K) begin
						exp_bank = 3'd1;
					end else if (model_q == zx_mem_pkg::MODEL_PLUS3) begin
						exp_bank = {1'b0, exp_1ffd[zx_mem_pkg::ROM_HI_BIT],
							exp_7ffd[zx_mem_pkg::ROM_LO_BIT]};
					end else begin
						exp_bank = {2'b00, exp_7ffd[zx_mem_pkg::ROM_LO_BIT]};
					end
				end
				2'd1:    exp_bank = 3'd5;
				2'd2:    exp_bank = 3'd2;
				default: exp_bank = exp_7ffd[2:0];
			endcase
		end
	end

	assign exp_ram_addr = {rom_win, exp_bank, addr[13:0]};

	// ====================
	// Checks
	// ====================

	a_address_map: assert property (@(posedge clk_sys) disable iff (reset)
		!mreq_n && (!rd_n || !wr_n) |-> ram_addr == exp_ram_addr)
		else record_failure("address_map", 32'(exp_ram_addr), 32'(ram_addr));

	a_read_enable: assert property (@(posedge clk_sys) disable iff (reset)
		ram_rd == (!mreq_n && !rd_n))
		else record_failure("read_enable", 32'(!mreq_n && !rd_n), 32'(ram_rd));

	a_rom_protect: assert property (@(posedge clk_sys) disable iff (reset)
		ram_we |-> addr[15:14] != 2'b00 || special)
		else record_failure("rom_protect", 32'd0, 32'(ram_we));

	a_write_enable: assert property (@(posedge clk_sys) disable iff (reset)
		addr[15:14] != 2'b00 || special |-> ram_we == (!mreq_n && !wr_n))
		else record_failure("write_enable", 32'(!mreq_n && !wr_n), 32'(ram_we));

	// Also covers the lock since the reference ignores locked writes
	a_screen_page: assert property (@(posedge clk_sys) disable iff (reset)
		screen_page == exp_7ffd[zx_mem_pkg::SCREEN_BIT])
		else record_failure("screen_page", 32'(exp_7ffd[zx_mem_pkg::SCREEN_BIT]),
			32'(screen_page));

	a_mem_read_data: assert property (@(posedge clk_sys) disable iff (reset)
		!mreq_n && !rd_n |-> cpu_din == ram_dout)
		else record_failure("mem_read_data", 32'(ram_dout), 32'(cpu_din));

	a_ula_read_data: assert property (@(posedge clk_sys) disable iff (reset)
		io_read && !addr[0] |-> cpu_din == {1'b1, tape_in, 1'b1, key_data})
		else record_failure("ula_read_data", 32'({1'b1, tape_in, 1'b1, key_data}),
			32'(cpu_din));

	a_float_read_data: assert property (@(posedge clk_sys) disable iff (reset)
		(io_read && addr[0]) || int_ack |-> cpu_din == 8'hFF)
		else record_failure("float_read_data", 32'hFF, 32'(cpu_din));

	a_border: assert property (@(posedge clk_sys) disable iff (reset)
		border_color == exp_fe[2:0])
		else record_failure("border", 32'(exp_fe[2:0]), 32'(border_color));

	a_quiet_audio: assert property (@(posedge clk_sys) disable iff (reset)
		quiet_q |-> !audio)
		else record_failure("quiet_audio", 32'd0, 32'(audio));

endmodule

// ==== testbench/zx_host_tb.sv ====
module zx_host_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int PHASES       = 3;
	localparam int PHASE_CYCLES = 300;
	localparam int BUS_CLOCKS   = 3;
	// Twice the nominal length of all three phases
	localparam int WATCHDOG_TIME = 2 * PHASES * PHASE_CYCLES * BUS_CLOCKS * CLK_PERIOD;

	logic                                clk_sys = 1'b0;
	logic                                reset;
	zx_mem_pkg::machine_t                machine;
	logic [zx_io_pkg::CPU_ADDR_W-1:0]    addr;
	logic [zx_io_pkg::DATA_W-1:0]        cpu_dout;
	logic                                mreq_n;
	logic                                iorq_n;
	logic                                rd_n;
	logic                                wr_n;
	logic                                m1_n;
	logic [zx_io_pkg::DATA_W-1:0]        ram_dout;
	logic                                tape_in;
	logic [4:0]                          key_data;
	logic [zx_io_pkg::DATA_W-1:0]        cpu_din;
	logic [zx_mem_pkg::MEM_ADDR_W-1:0]   ram_addr;
	logic                                ram_rd;
	logic                                ram_we;
	logic                                screen_page;
	logic [2:0]                          border_color;
	logic                                audio;
	integer                              seed = 32'h777f940f;

	zx_host i_zx_host (.*);

	bind zx_host zx_host_properties i_zx_host_properties (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// One Z80 cycle with strobes low for two clocks and then one idle clock
	task automatic bus_cycle(input logic io, input logic write,
			input logic [15:0] a, input logic [7:0] d);
		logic [31:0] r;
		r = $random(seed);
		@(posedge clk_sys);
		addr     <= a;
		cpu_dout <= d;
		mreq_n   <= io;
		iorq_n   <= !io;
		rd_n     <= write;
		wr_n     <= !write;
		// Some I/O cycles become interrupt acknowledges
		m1_n     <= !(io && r[16:14] == 3'b111);
		ram_dout <= r[7:0];
		tape_in  <= r[8];
		key_data <= r[13:9];
		repeat (BUS_CLOCKS - 1) @(posedge clk_sys);
		mreq_n <= 1'b1;
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
	endtask

	task automatic run_phase(input zx_mem_pkg::machine_t model);
		logic [31:0] kind;
		logic [31:0] a;
		logic [31:0] d;
		@(posedge clk_sys);
		reset   <= 1'b1;
		machine <= model;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		for (int i = 0; i < PHASE_CYCLES; i++) begin
			kind = $random(seed);
			a    = $random(seed);
			d    = $random(seed);
			// Lock only near the end so paging stays reachable
			if (i < PHASE_CYCLES - 30) begin
				d[zx_mem_pkg::LOCK_BIT] = 1'b0;
			end
			case (kind[2:0])
				3'd0, 3'd1: bus_cycle(1'b0, 1'b0, a[15:0], d[7:0]);
				3'd2:       bus_cycle(1'b0, 1'b1, a[15:0], d[7:0]);
				3'd3:       bus_cycle(1'b0, 1'b1, {2'b00, a[13:0]}, d[7:0]);
				3'd4:       bus_cycle(1'b1, 1'b1, 16'h7FFD, d[7:0]);
				3'd5:       bus_cycle(1'b1, 1'b1, 16'h1FFD, d[7:0]);
				3'd6:       bus_cycle(1'b1, 1'b1, {a[7:0], 8'hFE}, d[7:0]);
				default:    bus_cycle(1'b1, 1'b0, a[15:0], d[7:0]);
			endcase
		end
	endtask

	task automatic report_failure();
		$display("CHECK FAILED %s expected %0h actual %0h",
			i_zx_host.i_zx_host_properties.fail_name,
			i_zx_host.i_zx_host_properties.fail_exp,
			i_zx_host.i_zx_host_properties.fail_act);
		$display("=== FAIL ===");
		$fatal(1, "%0d assertion failures", i_zx_host.i_zx_host_properties.fail_count);
	endtask

	// Stop at the first failed assertion
	always @(negedge clk_sys) begin
		if (i_zx_host.i_zx_host_properties.fail_count != 0) begin
			report_failure();
		end
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("=== FAIL ===");
		$fatal(1, "Watchdog expired before the bus sequence finished");
	end

	initial begin
		reset    = 1'b1;
		machine  = zx_mem_pkg::MODEL_128K;
		addr     = '0;
		cpu_dout = '0;
		mreq_n   = 1'b1;
		iorq_n   = 1'b1;
		rd_n     = 1'b1;
		wr_n     = 1'b1;
		m1_n     = 1'b1;
		ram_dout = '0;
		tape_in  = 1'b0;
		key_data = '0;
		run_phase(zx_mem_pkg::MODEL_128K);
		run_phase(zx_mem_pkg::MODEL_PLUS3);
		run_phase(zx_mem_pkg::MODEL_48K);
		@(posedge clk_sys);
		if (i_zx_host.i_zx_host_properties.fail_count != 0) begin
			report_failure();
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

// ==== all.f ====
src/zx_io_pkg.sv
src/zx_mem_pkg.sv
src/zx_bus_ctrl.sv
src/zx_paging.sv
src/zx_ram_map.sv
src/zx_ula_port.sv
src/zx_host.sv
testbench/zx_host_properties.sv
testbench/zx_host_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --assert --top-module zx_host_tb -f all.f -o zx_host_sim \
	&& ./obj_dir/zx_host_sim +verilator+error+limit+1000 \
	|| exit 1
